//--- include/lar_cpu_defs.svh
`ifndef LAR_CPU_DEFS_SVH
`define LAR_CPU_DEFS_SVH

// word and datapath widths
`define LAR_INSTR_W 32
`define LAR_ADDR_W 16
`define LAR_DATA_W 32
`define LAR_REG_IDX_W 4
`define LAR_IMM_W 14

// instruction store, word indexed
`define LAR_IMEM_WORDS 256
`define LAR_IMEM_IDX_W 8

// data memory and its access latency in cycles
`define LAR_DMEM_WORDS 64
`define LAR_DMEM_IDX_W 6
`define LAR_DMEM_LAT 3

// instruction word fields
`define LAR_GROUP_HI 31
`define LAR_GROUP_LO 30
`define LAR_OPER_HI 29
`define LAR_OPER_LO 26
`define LAR_RA_HI 25
`define LAR_RA_LO 22
`define LAR_RB_HI 21
`define LAR_RB_LO 18
`define LAR_RC_HI 17
`define LAR_RC_LO 14
`define LAR_IMM_HI 13
`define LAR_IMM_LO 0

`endif

//--- hw/lar_cpu_pkg.sv
`default_nettype none

`include "lar_cpu_defs.svh"

package lar_cpu_pkg;

	// top two bits of every word
	typedef enum logic [1:0]
	{
		grp_alu,
		grp_ctrl,
		grp_load,
		grp_store
	} instr_group_e;

	// oper field when group is alu
	typedef enum logic [3:0]
	{
		alu_add,
		alu_sub,
		alu_and,
		alu_or
	} alu_op_e;

	// oper field when group is ctrl
	typedef enum logic [3:0]
	{
		ctrl_jump,
		ctrl_branch_zero,
		ctrl_halt
	} ctrl_op_e;

	typedef enum logic [2:0]
	{
		st_init,
		st_regular,
		st_change_pc,
		st_wait_mem0,
		st_wait_mem1,
		st_halt
	} fetch_state_e;

	// nop flag sits in the lsb
	typedef struct packed
	{
		instr_group_e group;
		logic [3:0] oper;
		logic [`LAR_REG_IDX_W-1:0] ra;
		logic [`LAR_REG_IDX_W-1:0] rb;
		logic [`LAR_REG_IDX_W-1:0] rc;
		logic [`LAR_DATA_W-1:0] imm;
		logic nop;
	} decoded_instr_t;

endpackage

`default_nettype wire

//--- hw/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "lar_cpu_defs.svh"

module instr_decoder
	import lar_cpu_pkg::*;
(
	input  logic [`LAR_INSTR_W-1:0] instr,
	output decoded_instr_t dec
);

	// zero bits above the immediate field
	localparam int IMM_PAD = `LAR_DATA_W - `LAR_IMM_W;

	logic [`LAR_IMM_W-1:0] imm_field;

	assign imm_field = instr[`LAR_IMM_HI:`LAR_IMM_LO];

	always_comb
	begin
		// group selects how oper is read further down
		dec.group = instr_group_e'(instr[`LAR_GROUP_HI:`LAR_GROUP_LO]);
		// alu_op_e or ctrl_op_e, cast by the user
		dec.oper = instr[`LAR_OPER_HI:`LAR_OPER_LO];

		// register indices, always sliced even if unused
		dec.ra = instr[`LAR_RA_HI:`LAR_RA_LO];
		dec.rb = instr[`LAR_RB_HI:`LAR_RB_LO];
		dec.rc = instr[`LAR_RC_HI:`LAR_RC_LO];

		// immediate is unsigned, targets only move forward
		dec.imm = {{IMM_PAD{1'b0}}, imm_field};

		// an all-zero word would read as add r0, r0, r0
		// so it is singled out as a nop
		dec.nop = (instr == '0);
	end

endmodule

`default_nettype wire

//--- hw/instr_fetch_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "lar_cpu_defs.svh"

module instr_fetch_decode
	import lar_cpu_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic [`LAR_INSTR_W-1:0] imem_instr,
	input  logic imem_valid,
	input  logic ex_stall,
	input  logic wb_stall,
	input  logic [`LAR_ADDR_W-1:0] computed_pc,
	output logic [`LAR_ADDR_W-1:0] imem_addr,
	output decoded_instr_t dec_instr,
	output logic [`LAR_ADDR_W-1:0] dec_pc,
	output logic [`LAR_REG_IDX_W-1:0] hint_ra,
	output logic [`LAR_REG_IDX_W-1:0] hint_rb,
	output logic [`LAR_REG_IDX_W-1:0] hint_rc,
	output logic halted
);

	localparam logic [`LAR_ADDR_W-1:0] INSTR_BYTES = `LAR_INSTR_W / 8;
	// only the nop flag set
	localparam decoded_instr_t BUBBLE =
		decoded_instr_t'({{($bits(decoded_instr_t) - 1){1'b0}}, 1'b1});

	fetch_state_e state;
	decoded_instr_t cur;
	logic [`LAR_ADDR_W-1:0] spec_pc;
	logic [`LAR_ADDR_W-1:0] following_pc;
	logic stall;

	instr_decoder u_decoder
	(
		.instr(imem_instr),
		.dec(cur)
	);

	assign following_pc = spec_pc + INSTR_BYTES;
	// either stall holds pc and state
	assign stall = ex_stall || wb_stall;

	// early register read for exec
	always_comb
	begin
		if ((state == st_regular) && imem_valid)
		begin
			hint_ra = cur.ra;
			hint_rb = cur.rb;
			hint_rc = cur.rc;
		end
		else
		begin
			hint_ra = '0;
			hint_rb = '0;
			hint_rc = '0;
		end
	end

	// store address follows the pc
	// a redirect goes out early, straight from exec
	always_comb
	begin
		case (state)
			st_change_pc:
			begin
				imem_addr = computed_pc;
			end
			default:
			begin
				imem_addr = spec_pc;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= st_init;
			spec_pc <= '0;
			dec_instr <= BUBBLE;
			dec_pc <= '0;
			halted <= 1'b0;
		end
		else
		begin
			// bubble unless a word is sent below
			dec_instr <= BUBBLE;
			halted <= (state == st_halt);
			case (state)
				st_init:
				begin
					if (imem_valid)
					begin
						state <= st_regular;
					end
				end
				st_regular:
				begin
					if (!stall && imem_valid)
					begin
						// nops are skipped here and never reach exec
						spec_pc <= following_pc;
						if (!cur.nop)
						begin
							dec_instr <= cur;
							dec_pc <= spec_pc;
							case (cur.group)
								grp_ctrl:
								begin
									// exec needs pc + 4 for a branch not taken
									dec_pc <= following_pc;
									if (ctrl_op_e'(cur.oper) == ctrl_halt)
									begin
										state <= st_halt;
									end
									else
									begin
										state <= st_change_pc;
									end
								end
								grp_load, grp_store:
								begin
									state <= st_wait_mem0;
								end
								default:
								begin
									state <= st_regular;
								end
							endcase
						end
					end
				end
				st_change_pc:
				begin
					spec_pc <= computed_pc;
					state <= st_regular;
				end
				st_wait_mem0:
				begin
					// wb_stall is not up yet in this cycle
					state <= st_wait_mem1;
				end
				st_wait_mem1:
				begin
					if (!wb_stall)
					begin
						state <= st_regular;
					end
				end
				default:
				begin
					// st_halt, stay until reset
					state <= st_halt;
				end
			endcase
		end
	end

	// halt goes out once, only bubbles after it
	assert property (@(posedge clk) disable iff (!rst_n)
		(state == st_halt) |=> dec_instr.nop);

	assert property (@(posedge clk) disable iff (!rst_n)
		(state == st_halt) |=> (state == st_halt));

endmodule

`default_nettype wire

//--- hw/instr_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "lar_cpu_defs.svh"

module instr_store
(
	input  logic clk,
	input  logic rst_n,
	input  logic prog_we,
	input  logic [`LAR_IMEM_IDX_W-1:0] prog_addr,
	input  logic [`LAR_INSTR_W-1:0] prog_data,
	input  logic [`LAR_ADDR_W-1:0] imem_addr,
	output logic [`LAR_INSTR_W-1:0] imem_instr,
	output logic imem_valid
);

	// byte address bits below the word index
	localparam int BYTE_SEL_W = $clog2(`LAR_INSTR_W / 8);

	logic [`LAR_INSTR_W-1:0] mem [`LAR_IMEM_WORDS];
	logic [`LAR_IMEM_IDX_W-1:0] rd_idx;
	logic [`LAR_ADDR_W-1:0] rd_addr;
	logic rd_live;

	// wraps modulo the store depth
	assign rd_idx = imem_addr[BYTE_SEL_W +: `LAR_IMEM_IDX_W];

	// load port, used while the core is held in reset
	always_ff @(posedge clk)
	begin
		if (prog_we)
		begin
			mem[prog_addr] <= prog_data;
		end
	end

	// word and the address it came from
	always_ff @(posedge clk)
	begin
		imem_instr <= mem[rd_idx];
		rd_addr <= imem_addr;
	end

	// no word counts while loading
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_live <= 1'b0;
		end
		else
		begin
			rd_live <= !prog_we;
		end
	end

	// a new address costs one cycle
	assign imem_valid = rd_live && (rd_addr == imem_addr);

endmodule

`default_nettype wire

//--- hw/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "lar_cpu_defs.svh"

module exec_stage
	import lar_cpu_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  decoded_instr_t dec_instr,
	input  logic [`LAR_ADDR_W-1:0] dec_pc,
	input  logic [`LAR_REG_IDX_W-1:0] hint_ra,
	input  logic [`LAR_REG_IDX_W-1:0] hint_rb,
	input  logic [`LAR_REG_IDX_W-1:0] hint_rc,
	input  logic [`LAR_DATA_W-1:0] dmem_rdata,
	input  logic wb_stall,
	output logic [`LAR_ADDR_W-1:0] computed_pc,
	output logic ex_stall,
	output logic dmem_req,
	output logic dmem_we,
	output logic [`LAR_DMEM_IDX_W-1:0] dmem_idx,
	output logic [`LAR_DATA_W-1:0] dmem_wdata,
	output logic retire_valid,
	output logic [`LAR_ADDR_W-1:0] retire_pc,
	output logic retire_we,
	output logic [`LAR_REG_IDX_W-1:0] retire_idx,
	output logic [`LAR_DATA_W-1:0] retire_data
);

	localparam int NUM_REGS = 1 << `LAR_REG_IDX_W;
	localparam logic [`LAR_ADDR_W-1:0] INSTR_BYTES = `LAR_INSTR_W / 8;
	localparam int PC_PAD = `LAR_DATA_W - `LAR_ADDR_W;

	logic [`LAR_DATA_W-1:0] regs [NUM_REGS];
	logic [`LAR_DATA_W-1:0] ra_val;
	logic [`LAR_DATA_W-1:0] rb_val;
	logic [`LAR_DATA_W-1:0] rc_val;
	logic [`LAR_DATA_W-1:0] alu_res;
	logic [`LAR_DATA_W-1:0] addr_sum;
	logic is_alu;
	logic is_ctrl;
	logic is_mem;
	logic mem_pending;
	logic mem_done;
	logic mem_load;
	logic [`LAR_ADDR_W-1:0] mem_pc;
	logic [`LAR_REG_IDX_W-1:0] mem_ra;
	logic [`LAR_DATA_W-1:0] mem_data;

	assign is_alu = !dec_instr.nop && (dec_instr.group == grp_alu);
	assign is_ctrl = !dec_instr.nop && (dec_instr.group == grp_ctrl);
	assign is_mem = !dec_instr.nop
		&& ((dec_instr.group == grp_load) || (dec_instr.group == grp_store));

	// shared by jump targets and memory indices
	assign addr_sum = rb_val + dec_instr.imm;

	// operands fetched with the hints, one edge ahead
	always_ff @(posedge clk)
	begin
		ra_val <= regs[hint_ra];
		rb_val <= regs[hint_rb];
		rc_val <= regs[hint_rc];
	end

	always_comb
	begin
		case (alu_op_e'(dec_instr.oper))
			alu_add: alu_res = rb_val + rc_val;
			alu_sub: alu_res = rb_val - rc_val;
			alu_and: alu_res = rb_val & rc_val;
			alu_or: alu_res = rb_val | rc_val;
			default: alu_res = '0;
		endcase
	end

	// dec_pc of a ctrl word is already pc + 4
	always_comb
	begin
		computed_pc = dec_pc;
		case (ctrl_op_e'(dec_instr.oper))
			ctrl_jump: computed_pc = addr_sum[`LAR_ADDR_W-1:0];
			ctrl_branch_zero:
			begin
				if (ra_val == '0)
				begin
					computed_pc = addr_sum[`LAR_ADDR_W-1:0];
				end
			end
			default: computed_pc = dec_pc;
		endcase
	end

	// request goes out in the cycle the word arrives
	assign dmem_req = is_mem;
	assign dmem_we = (dec_instr.group == grp_store);
	assign dmem_idx = addr_sum[`LAR_DMEM_IDX_W-1:0];
	assign dmem_wdata = ra_val;
	assign ex_stall = mem_pending || is_mem;
	// wb_stall drops when the data is on dmem_rdata
	assign mem_done = mem_pending && !wb_stall;

	// held until the data port answers
	always_ff @(posedge clk)
	begin
		if (is_mem)
		begin
			mem_pc <= dec_pc;
			mem_ra <= dec_instr.ra;
			mem_load <= (dec_instr.group == grp_load);
			mem_data <= ra_val;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mem_pending <= 1'b0;
		end
		else if (is_mem)
		begin
			mem_pending <= 1'b1;
		end
		else if (mem_done)
		begin
			mem_pending <= 1'b0;
		end
	end

	// registers start at zero
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (is_alu)
		begin
			regs[dec_instr.ra] <= alu_res;
		end
		else if (mem_done && mem_load)
		begin
			regs[mem_ra] <= dmem_rdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			retire_valid <= 1'b0;
			retire_pc <= '0;
			retire_we <= 1'b0;
			retire_idx <= '0;
			retire_data <= '0;
		end
		else
		begin
			retire_valid <= is_alu || is_ctrl || mem_done;
			if (is_alu)
			begin
				retire_pc <= dec_pc;
				retire_we <= 1'b1;
				retire_idx <= dec_instr.ra;
				retire_data <= alu_res;
			end
			else if (is_ctrl)
			begin
				// report the control word's own pc and where fetch goes
				retire_pc <= dec_pc - INSTR_BYTES;
				retire_we <= 1'b0;
				retire_idx <= '0;
				retire_data <= {{PC_PAD{1'b0}}, computed_pc};
			end
			else if (mem_done)
			begin
				// a store reports the word it wrote
				retire_pc <= mem_pc;
				retire_we <= mem_load;
				retire_idx <= mem_ra;
				retire_data <= mem_load ? dmem_rdata : mem_data;
			end
		end
	end

	// fetch must hold memory words back until the port is free
	assert property (@(posedge clk) disable iff (!rst_n)
		dmem_req |-> (!mem_pending && !wb_stall));

endmodule

`default_nettype wire

//--- hw/data_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "lar_cpu_defs.svh"

module data_port
(
	input  logic clk,
	input  logic rst_n,
	input  logic dmem_req,
	input  logic dmem_we,
	input  logic [`LAR_DMEM_IDX_W-1:0] dmem_idx,
	input  logic [`LAR_DATA_W-1:0] dmem_wdata,
	output logic [`LAR_DATA_W-1:0] dmem_rdata,
	output logic wb_stall
);

	localparam int CNT_W = $clog2(`LAR_DMEM_LAT + 1);
	localparam logic [CNT_W-1:0] LAT = `LAR_DMEM_LAT;

	logic [`LAR_DATA_W-1:0] mem [`LAR_DMEM_WORDS];
	logic [CNT_W-1:0] cnt;
	logic access;
	logic req_we;
	logic [`LAR_DMEM_IDX_W-1:0] req_idx;
	logic [`LAR_DATA_W-1:0] req_wdata;

	// busy from the request edge to the data edge
	assign wb_stall = (cnt != '0);
	// last counted cycle, the array is touched here
	assign access = (cnt == CNT_W'(1));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt <= '0;
		end
		else if (dmem_req)
		begin
			cnt <= LAT;
		end
		else if (cnt != '0)
		begin
			cnt <= cnt - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (dmem_req)
		begin
			req_we <= dmem_we;
			req_idx <= dmem_idx;
			req_wdata <= dmem_wdata;
		end
	end

	// contents start at zero
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `LAR_DMEM_WORDS; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (access && req_we)
		begin
			mem[req_idx] <= req_wdata;
		end
	end

	// valid on the edge wb_stall falls
	always_ff @(posedge clk)
	begin
		if (access && !req_we)
		begin
			dmem_rdata <= mem[req_idx];
		end
	end

endmodule

`default_nettype wire

//--- hw/lar_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lar_cpu_defs.svh"

module lar_cpu_top
	import lar_cpu_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic prog_we,
	input  logic [`LAR_IMEM_IDX_W-1:0] prog_addr,
	input  logic [`LAR_INSTR_W-1:0] prog_data,
	output logic retire_valid,
	output logic [`LAR_ADDR_W-1:0] retire_pc,
	output logic retire_we,
	output logic [`LAR_REG_IDX_W-1:0] retire_idx,
	output logic [`LAR_DATA_W-1:0] retire_data,
	output logic halted
);

	// fetch side
	logic [`LAR_ADDR_W-1:0] imem_addr;
	logic [`LAR_INSTR_W-1:0] imem_instr;
	logic imem_valid;
	decoded_instr_t dec_instr;
	logic [`LAR_ADDR_W-1:0] dec_pc;
	logic [`LAR_REG_IDX_W-1:0] hint_ra;
	logic [`LAR_REG_IDX_W-1:0] hint_rb;
	logic [`LAR_REG_IDX_W-1:0] hint_rc;
	logic [`LAR_ADDR_W-1:0] computed_pc;
	logic ex_stall;

	// data side
	logic dmem_req;
	logic dmem_we;
	logic [`LAR_DMEM_IDX_W-1:0] dmem_idx;
	logic [`LAR_DATA_W-1:0] dmem_wdata;
	logic [`LAR_DATA_W-1:0] dmem_rdata;
	// seen by fetch and exec alike
	logic wb_stall;

	instr_store u_imem
	(
		.clk(clk),
		.rst_n(rst_n),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.imem_addr(imem_addr),
		.imem_instr(imem_instr),
		.imem_valid(imem_valid)
	);

	instr_fetch_decode u_fetch
	(
		.clk(clk),
		.rst_n(rst_n),
		.imem_instr(imem_instr),
		.imem_valid(imem_valid),
		.ex_stall(ex_stall),
		.wb_stall(wb_stall),
		.computed_pc(computed_pc),
		.imem_addr(imem_addr),
		.dec_instr(dec_instr),
		.dec_pc(dec_pc),
		.hint_ra(hint_ra),
		.hint_rb(hint_rb),
		.hint_rc(hint_rc),
		.halted(halted)
	);

	exec_stage u_exec
	(
		.clk(clk),
		.rst_n(rst_n),
		.dec_instr(dec_instr),
		.dec_pc(dec_pc),
		.hint_ra(hint_ra),
		.hint_rb(hint_rb),
		.hint_rc(hint_rc),
		.dmem_rdata(dmem_rdata),
		.wb_stall(wb_stall),
		.computed_pc(computed_pc),
		.ex_stall(ex_stall),
		.dmem_req(dmem_req),
		.dmem_we(dmem_we),
		.dmem_idx(dmem_idx),
		.dmem_wdata(dmem_wdata),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_we(retire_we),
		.retire_idx(retire_idx),
		.retire_data(retire_data)
	);

	data_port u_dmem
	(
		.clk(clk),
		.rst_n(rst_n),
		.dmem_req(dmem_req),
		.dmem_we(dmem_we),
		.dmem_idx(dmem_idx),
		.dmem_wdata(dmem_wdata),
		.dmem_rdata(dmem_rdata),
		.wb_stall(wb_stall)
	);

endmodule

`default_nettype wire

//--- bench/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen
(
	output logic clk,
	output logic rst_n
);

	localparam int RST_CYCLES = 16;

	// 10 ns period
	initial
	begin
		clk = 1'b0;
		forever
		begin
			#5 clk = ~clk;
		end
	end

	// release on a falling edge, clear of the sampling edge
	initial
	begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- bench/tb_lar_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "lar_cpu_defs.svh"

module tb_lar_cpu;

	localparam int PROG_WORDS = 120;
	localparam int SEED = 65972;
	localparam int QUIET_CYCLES = 20;
	// worst case per word is a memory access plus the fetch turnaround
	localparam int TIMEOUT_CYCLES = PROG_WORDS * (`LAR_DMEM_LAT + 4) + 200;

	logic clk;
	logic rst_n;
	logic prog_we;
	logic [`LAR_IMEM_IDX_W-1:0] prog_addr;
	logic [`LAR_INSTR_W-1:0] prog_data;
	logic retire_valid;
	logic [`LAR_ADDR_W-1:0] retire_pc;
	logic retire_we;
	logic [`LAR_REG_IDX_W-1:0] retire_idx;
	logic [`LAR_DATA_W-1:0] retire_data;
	logic halted;

	// program image and model state
	logic [`LAR_INSTR_W-1:0] prog [PROG_WORDS];
	logic [`LAR_DATA_W-1:0] m_regs [16];
	logic [`LAR_DATA_W-1:0] m_dmem [`LAR_DMEM_WORDS];

	// expected retire trace with one entry per non-nop word executed
	logic [`LAR_ADDR_W-1:0] exp_pc [$];
	logic exp_we [$];
	logic [`LAR_REG_IDX_W-1:0] exp_idx [$];
	logic [`LAR_DATA_W-1:0] exp_data [$];
	int exp_kind [$];

	int beh_chk [1:6] = '{default: 0};
	int beh_err [1:6] = '{default: 0};
	int passes = 0;
	int fails = 0;
	int retire_count = 0;
	int exp_total = 0;
	int prev_kind = 0;
	int cycles = 0;
	int taken = 0;
	int not_taken = 0;
	int extra = 0;
	logic run_phase;
	logic run_done;

	clk_gen u_clk
	(
		.clk(clk),
		.rst_n(rst_n)
	);

	lar_cpu_top dut0
	(
		.clk(clk),
		.rst_n(rst_n),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_we(retire_we),
		.retire_idx(retire_idx),
		.retire_data(retire_data),
		.halted(halted)
	);

	// group, oper, ra, rb, rc, imm from msb down
	function automatic logic [31:0] make_word(input int grp, input int op, input int ra,
		input int rb, input int rc, input int imm);
		make_word = {grp[1:0], op[3:0], ra[3:0], rb[3:0], rc[3:0], imm[13:0]};
	endfunction

	// forward target 1 to 6 words ahead and never past the halt
	function automatic int pick_target(input int i);
		int w;
		w = i + $urandom_range(6, 1);
		if (w > PROG_WORDS - 1)
		begin
			w = PROG_WORDS - 1;
		end
		return w * 4;
	endfunction

	function automatic logic [31:0] alu_result(input int op, input logic [31:0] b,
		input logic [31:0] c);
		case (op)
			0: return b + c;
			1: return b - c;
			2: return b & c;
			default: return b | c;
		endcase
	endfunction

	function automatic string behavior_name(input int b);
		case (b)
			1: return "alu order";
			2: return "jump redirect";
			3: return "branch zero";
			4: return "store then load";
			5: return "halt";
			default: return "retire count";
		endcase
	endfunction

	task automatic compare(input int beh, input string what, input logic [31:0] got,
		input logic [31:0] exp);
		beh_chk[beh]++;
		if (got !== exp)
		begin
			$display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
			fails++;
			beh_err[beh]++;
		end
		else
		begin
			passes++;
		end
	endtask

	task automatic gen_program;
		int r;
		for (int i = 0; i < PROG_WORDS - 1; i++)
		begin
			r = $urandom_range(99, 0);
			// writers keep ra off r0 so r0 plus imm is an absolute target
			if (r < 8)
				prog[i] = '0;
			else if (r < 58)
				prog[i] = make_word(0, $urandom_range(3, 0), $urandom_range(15, 1),
					$urandom_range(15, 0), $urandom_range(15, 0), 0);
			else if (r < 70)
				prog[i] = make_word(1, 0, 0, 0, 0, pick_target(i));
			else if (r < 82)
				prog[i] = make_word(1, 1, $urandom_range(15, 0), 0, 0, pick_target(i));
			else if (r < 91)
				prog[i] = make_word(3, 0, $urandom_range(15, 0), 0, 0, $urandom_range(7, 0));
			else
				prog[i] = make_word(2, 0, $urandom_range(15, 1), 0, 0, $urandom_range(7, 0));
		end
		prog[PROG_WORDS - 1] = make_word(1, 2, 0, 0, 0, 0);
	endtask

	task automatic add_expected(input logic [15:0] pc, input logic we, input int idx,
		input logic [31:0] data, input int kind);
		exp_pc.push_back(pc);
		exp_we.push_back(we);
		exp_idx.push_back(idx[3:0]);
		exp_data.push_back(data);
		exp_kind.push_back(kind);
	endtask

	// instruction-level model run to halt before the DUT starts
	task automatic build_trace;
		logic [15:0] pc;
		logic [15:0] next_pc;
		logic [31:0] w;
		logic [31:0] imm;
		logic [31:0] sum;
		logic [31:0] data;
		int grp;
		int op;
		int ra;
		int rb;
		int rc;
		int steps;
		logic done;
		pc = '0;
		done = 1'b0;
		steps = 0;
		foreach (m_regs[i])
		begin
			m_regs[i] = '0;
		end
		foreach (m_dmem[i])
		begin
			m_dmem[i] = '0;
		end
		while (!done && steps < PROG_WORDS)
		begin
			w = prog[pc >> 2];
			steps++;
			next_pc = pc + 16'd4;
			grp = w[`LAR_GROUP_HI:`LAR_GROUP_LO];
			op = w[`LAR_OPER_HI:`LAR_OPER_LO];
			ra = w[`LAR_RA_HI:`LAR_RA_LO];
			rb = w[`LAR_RB_HI:`LAR_RB_LO];
			rc = w[`LAR_RC_HI:`LAR_RC_LO];
			imm = w[`LAR_IMM_HI:`LAR_IMM_LO];
			sum = m_regs[rb] + imm;
			// an all-zero word is a nop and is skipped
			if (w != '0)
			begin
				case (grp)
					0:
					begin
						data = alu_result(op, m_regs[rb], m_regs[rc]);
						m_regs[ra] = data;
						add_expected(pc, 1'b1, ra, data, 1);
					end
					1:
					begin
						if (op == 0)
						begin
							next_pc = sum[15:0];
							add_expected(pc, 1'b0, 0, next_pc, 2);
						end
						else if (op == 1)
						begin
							if (m_regs[ra] == '0)
							begin
								next_pc = sum[15:0];
								taken++;
							end
							else
							begin
								not_taken++;
							end
							add_expected(pc, 1'b0, 0, next_pc, 3);
						end
						else
						begin
							add_expected(pc, 1'b0, 0, next_pc, 5);
							done = 1'b1;
						end
					end
					2:
					begin
						data = m_dmem[sum % `LAR_DMEM_WORDS];
						m_regs[ra] = data;
						add_expected(pc, 1'b1, ra, data, 4);
					end
					default:
					begin
						m_dmem[sum % `LAR_DMEM_WORDS] = m_regs[ra];
						add_expected(pc, 1'b0, ra, m_regs[ra], 4);
					end
				endcase
			end
			pc = next_pc;
		end
		exp_total = exp_pc.size();
	endtask

	task automatic check_retire;
		int kind;
		int pc_beh;
		if (exp_pc.size() == 0)
		begin
			$display("retire at pc %h came after the model had already halted, time %0t",
				retire_pc, $time);
			fails++;
			beh_err[6]++;
		end
		else
		begin
			kind = exp_kind.pop_front();
			// pc right after a redirect belongs to the jump or branch
			pc_beh = ((prev_kind == 2) || (prev_kind == 3)) ? prev_kind : kind;
			compare(pc_beh, "retire_pc", retire_pc, exp_pc.pop_front());
			compare(kind, "retire_we", retire_we, exp_we.pop_front());
			compare(kind, "retire_idx", retire_idx, exp_idx.pop_front());
			compare(kind, "retire_data", retire_data, exp_data.pop_front());
			if (kind != 5)
			begin
				compare(5, "halted before halt retired", halted, 1'b0);
			end
			prev_kind = kind;
		end
		retire_count++;
	endtask

	task automatic report(input int b);
		string note;
		note = "";
		if (b == 3)
		begin
			// how the random branches split in the model
			note = $sformatf(", branches taken %0d, not taken %0d", taken, not_taken);
		end
		$display("behavior %0d (%s): %0d checks, %0d errors, %s%s", b, behavior_name(b),
			beh_chk[b], beh_err[b], (beh_err[b] == 0) ? "ok" : "bad", note);
	endtask

	// watchdog counts from the end of program loading
	always @(posedge clk)
	begin
		if (run_phase)
		begin
			cycles = cycles + 1;
			if (cycles >= TIMEOUT_CYCLES)
			begin
				$display("timeout: the core did not finish within %0d cycles", TIMEOUT_CYCLES);
				$display("Simulation failed");
				$finish;
			end
		end
	end

	initial
	begin
		void'($urandom(SEED));
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		run_phase = 1'b0;
		run_done = 1'b0;
		gen_program();
		build_trace();

		// load starts under reset and fetch idles in st_init until prog_we drops
		for (int i = 0; i < PROG_WORDS; i++)
		begin
			@(negedge clk);
			prog_we = 1'b1;
			prog_addr = i[`LAR_IMEM_IDX_W-1:0];
			prog_data = prog[i];
		end
		@(negedge clk);
		prog_we = 1'b0;
		run_phase = 1'b1;

		// retire outputs are registered and stable at the falling edge
		while (!run_done)
		begin
			@(negedge clk);
			if (retire_valid)
			begin
				check_retire();
			end
			if (halted)
			begin
				run_done = 1'b1;
			end
		end
		compare(5, "last retire before halted", prev_kind, 5);
		for (int b = 1; b <= 4; b++)
		begin
			report(b);
		end

		// nothing may retire once halted
		repeat (QUIET_CYCLES)
		begin
			@(negedge clk);
			if (retire_valid)
			begin
				extra++;
			end
			compare(5, "halted level", halted, 1'b1);
		end
		compare(5, "retires after halt", extra, 0);
		report(5);

		compare(6, "retire count", retire_count, exp_total);
		report(6);

		$display("checks passed %0d, checks failed %0d", passes, fails);
		if (fails == 0)
		begin
			$display("Simulation passed");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- lar_cpu.f
+incdir+include
hw/lar_cpu_pkg.sv
hw/instr_decoder.sv
hw/instr_fetch_decode.sv
hw/instr_store.sv
hw/exec_stage.sv
hw/data_port.sv
hw/lar_cpu_top.sv
bench/clk_gen.sv
bench/tb_lar_cpu.sv

//--- Bender.yml
package:
  name: lar_cpu

sources:
  - include_dirs:
      - include
    files:
      - hw/lar_cpu_pkg.sv
      - hw/instr_decoder.sv
      - hw/instr_fetch_decode.sv
      - hw/instr_store.sv
      - hw/exec_stage.sv
      - hw/data_port.sv
      - hw/lar_cpu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/clk_gen.sv
      - bench/tb_lar_cpu.sv
